// File: mips_defs.svh
/*
 * Shared constants for the single-cycle MIPS core: reset PC, word widths,
 * opcode and funct encodings of the supported instructions and the fixed
 * link register. Include wherever an encoding or width is needed.
 */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define MIPS_TEXT_START 32'h0040_0000 // byte address of first instruction
`define MIPS_WORD_W     32
`define MIPS_ADDR_W     30            // word address, byte offset dropped

`define MIPS_REG_RA     5'd31         // jal link target

// primary opcodes, inst[31:26]
`define MIPS_OP_RTYPE   6'h00
`define MIPS_OP_J       6'h02
`define MIPS_OP_JAL     6'h03
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_BNE     6'h05
`define MIPS_OP_ADDI    6'h08
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_SLTI    6'h0a
`define MIPS_OP_ANDI    6'h0c
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_XORI    6'h0e
`define MIPS_OP_LUI     6'h0f
`define MIPS_OP_LB      6'h20
`define MIPS_OP_LH      6'h21
`define MIPS_OP_LW      6'h23
`define MIPS_OP_LBU     6'h24
`define MIPS_OP_LHU     6'h25
`define MIPS_OP_SW      6'h2b

// funct codes, inst[5:0], opcode 0 only
`define MIPS_FN_SLL     6'h00
`define MIPS_FN_SRL     6'h02
`define MIPS_FN_SRA     6'h03
`define MIPS_FN_SLLV    6'h04
`define MIPS_FN_SRLV    6'h06
`define MIPS_FN_SRAV    6'h07
`define MIPS_FN_JR      6'h08
`define MIPS_FN_SYSCALL 6'h0c
`define MIPS_FN_ADD     6'h20
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUB     6'h22
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_NOR     6'h27
`define MIPS_FN_SLT     6'h2a

`endif

// File: mips_pkg.sv
/*
 * Control types passed from the decoder to the datapath units.
 * Import with a wildcard in the module header.
 */
package mips_pkg;

   // add/addu and sub/subu share an encoding, no overflow traps
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB,
      ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT,
      ALU_SLL, ALU_SRL, ALU_SRA,     // shift by shamt
      ALU_SLLV, ALU_SRLV, ALU_SRAV   // shift by rs[4:0]
   } alu_op_t;

   typedef enum logic [2:0] {
      LD_LW, LD_LB, LD_LBU, LD_LH, LD_LHU,
      LD_LUI                         // not a load, built from imm
   } load_sel_t;

   typedef enum logic [1:0] {
      PC_SEQ, PC_BRANCH, PC_REG, PC_JUMP
   } pc_sel_t;

   typedef enum logic [1:0] {
      WB_ALU, WB_LOAD, WB_LINK
   } wb_sel_t;

endpackage

// File: mips_decode.sv
/*
 * Instruction decoder. Purely combinational: maps opcode and funct to
 * datapath controls. Syscall and any unknown encoding raise halt_req
 * and leave reg_we and store low.
 */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_decode import mips_pkg::*; (
   input  logic [31:0] inst,
   output alu_op_t     alu_op,
   output logic        alu_src_imm,  // b operand from immediate
   output logic        sign_ext,     // sign vs zero extend imm
   output logic        reg_dst_rd,   // write rd, else rt
   output logic        link,         // write r31
   output logic        reg_we,
   output logic        store,
   output logic        halt_req,
   output pc_sel_t     pc_sel,
   output logic        branch_ne,    // bne, invert compare
   output wb_sel_t     wb_sel,
   output load_sel_t   load_sel
);

   logic [5:0] opcode;
   logic [5:0] funct;

   assign opcode = inst[31:26];
   assign funct  = inst[5:0];

   always_comb begin
      alu_op      = ALU_ADD;  // address calc default
      alu_src_imm = 1'b0;
      sign_ext    = 1'b1;
      reg_dst_rd  = 1'b0;
      link        = 1'b0;
      reg_we      = 1'b0;
      store       = 1'b0;
      halt_req    = 1'b0;
      pc_sel      = PC_SEQ;
      branch_ne   = 1'b0;
      wb_sel      = WB_ALU;
      load_sel    = LD_LW;

      case (opcode)
         `MIPS_OP_RTYPE: begin
            reg_dst_rd = 1'b1;
            reg_we     = 1'b1;     // cleared below for jr, syscall, unknown
            case (funct)
               `MIPS_FN_ADD, `MIPS_FN_ADDU: alu_op = ALU_ADD;
               `MIPS_FN_SUB, `MIPS_FN_SUBU: alu_op = ALU_SUB;
               `MIPS_FN_AND:  alu_op = ALU_AND;
               `MIPS_FN_OR:   alu_op = ALU_OR;
               `MIPS_FN_XOR:  alu_op = ALU_XOR;
               `MIPS_FN_NOR:  alu_op = ALU_NOR;
               `MIPS_FN_SLT:  alu_op = ALU_SLT;
               `MIPS_FN_SLL:  alu_op = ALU_SLL;
               `MIPS_FN_SRL:  alu_op = ALU_SRL;
               `MIPS_FN_SRA:  alu_op = ALU_SRA;
               `MIPS_FN_SLLV: alu_op = ALU_SLLV;
               `MIPS_FN_SRLV: alu_op = ALU_SRLV;
               `MIPS_FN_SRAV: alu_op = ALU_SRAV;
               `MIPS_FN_JR: begin
                  reg_we = 1'b0;
                  pc_sel = PC_REG;
               end
               default: begin      // syscall and reserved funct
                  reg_we   = 1'b0;
                  halt_req = 1'b1;
               end
            endcase
         end
         `MIPS_OP_J: pc_sel = PC_JUMP;
         `MIPS_OP_JAL: begin
            pc_sel = PC_JUMP;
            link   = 1'b1;
            reg_we = 1'b1;
            wb_sel = WB_LINK;     // pc+4, no delay slot
         end
         `MIPS_OP_BEQ: pc_sel = PC_BRANCH;
         `MIPS_OP_BNE: begin
            pc_sel    = PC_BRANCH;
            branch_ne = 1'b1;
         end
         `MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI,
         `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI: begin
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
            case (opcode)
               `MIPS_OP_SLTI: alu_op = ALU_SLT;
               `MIPS_OP_ANDI: alu_op = ALU_AND;
               `MIPS_OP_ORI:  alu_op = ALU_OR;
               `MIPS_OP_XORI: alu_op = ALU_XOR;
               default:       alu_op = ALU_ADD;
            endcase
            // logic immediates are zero extended
            sign_ext = !(opcode inside {`MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI});
         end
         `MIPS_OP_LUI: begin
            reg_we   = 1'b1;
            wb_sel   = WB_LOAD;
            load_sel = LD_LUI;
         end
         `MIPS_OP_LW, `MIPS_OP_LB, `MIPS_OP_LBU, `MIPS_OP_LH, `MIPS_OP_LHU: begin
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
            wb_sel      = WB_LOAD;
            case (opcode)
               `MIPS_OP_LB:  load_sel = LD_LB;
               `MIPS_OP_LBU: load_sel = LD_LBU;
               `MIPS_OP_LH:  load_sel = LD_LH;
               `MIPS_OP_LHU: load_sel = LD_LHU;
               default:      load_sel = LD_LW;
            endcase
         end
         `MIPS_OP_SW: begin
            alu_src_imm = 1'b1;
            store       = 1'b1;
         end
         default: halt_req = 1'b1; // reserved opcode
      endcase
   end

endmodule

// File: mips_alu.sv
/*
 * Combinational ALU. a is rs, b is rt or the extended immediate.
 * Constant shifts move b by shamt, variable shifts move b by a[4:0].
 */
`timescale 1ns/1ps

module mips_alu import mips_pkg::*; (
   input  alu_op_t     op,
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  logic [4:0]  shamt,
   output logic [31:0] y
);

   logic [4:0] vshift;

   assign vshift = a[4:0];   // only low 5 bits count

   always_comb begin
      case (op)
         ALU_ADD:  y = a + b;
         ALU_SUB:  y = a - b;
         ALU_AND:  y = a & b;
         ALU_OR:   y = a | b;
         ALU_XOR:  y = a ^ b;
         ALU_NOR:  y = ~(a | b);
         ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
         ALU_SLL:  y = b << shamt;
         ALU_SRL:  y = b >> shamt;
         ALU_SRA:  y = $unsigned($signed(b) >>> shamt);
         ALU_SLLV: y = b << vshift;
         ALU_SRLV: y = b >> vshift;
         ALU_SRAV: y = $unsigned($signed(b) >>> vshift);
         default:  y = a + b;
      endcase
   end

endmodule

// File: mips_regfile.sv
/*
 * 32 x 32 register file, two combinational read ports and one write
 * port taken at the rising edge. r0 is never written so it reads zero.
 */
`timescale 1ns/1ps

module mips_regfile (
   input  logic        clk,
   input  logic        rst_b,
   input  logic [4:0]  rs_addr,
   input  logic [4:0]  rt_addr,
   input  logic [4:0]  wr_addr,
   input  logic [31:0] wr_data,
   input  logic        we,
   output logic [31:0] rs_data,
   output logic [31:0] rt_data
);

   logic [31:0] regs [32];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wr_addr != 5'd0) begin  // drop writes to r0
         regs[wr_addr] <= wr_data;
      end
   end

   // no bypass, a write shows up next cycle
   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

endmodule

// File: mips_fetch.sv
/*
 * Program counter and halt state. Resolves beq/bne, j/jal and jr within
 * the cycle, no delay slot. Any halt request freezes pc and sets halted,
 * which only reset clears.
 */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_fetch import mips_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_b,
   input  pc_sel_t                 pc_sel,
   input  logic                    branch_ne,
   input  logic [`MIPS_WORD_W-1:0] rs_data,
   input  logic [`MIPS_WORD_W-1:0] rt_data,
   input  logic [15:0]             offset,
   input  logic [25:0]             target,
   input  logic                    halt_req,
   input  logic                    inst_excpt,
   output logic [`MIPS_ADDR_W-1:0] inst_addr,
   output logic [`MIPS_WORD_W-1:0] pc_plus4,
   output logic                    halted
);

   logic [`MIPS_WORD_W-1:0] pc;
   logic [`MIPS_WORD_W-1:0] br_target;
   logic [`MIPS_WORD_W-1:0] next_pc;
   logic                    taken;
   logic                    stop;

   assign pc_plus4  = pc + 32'd4;
   assign br_target = pc_plus4 + {{14{offset[15]}}, offset, 2'b00};
   assign taken     = (rs_data == rt_data) ^ branch_ne;
   assign stop      = halted | halt_req | inst_excpt;
   assign inst_addr = pc[31:2];

   always_comb begin
      case (pc_sel)
         PC_BRANCH: next_pc = taken ? br_target : pc_plus4;
         PC_REG:    next_pc = rs_data;                       // jr
         PC_JUMP:   next_pc = {pc[31:28], target, 2'b00};    // j, jal
         default:   next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= `MIPS_TEXT_START;
         halted <= 1'b0;
      end else begin
         halted <= stop;           // sticky until reset
         if (!stop) pc <= next_pc; // halting instruction keeps its pc
      end
   end

endmodule

// File: mips_writeback.sv
/*
 * Register write data path. Shapes the loaded word (byte or half-word
 * always taken from the low end), builds the lui value, then picks ALU
 * result, load value or the pc+4 link address.
 */
`timescale 1ns/1ps

module mips_writeback import mips_pkg::*; (
   input  wb_sel_t     wb_sel,
   input  load_sel_t   load_sel,
   input  logic [31:0] alu_out,
   input  logic [31:0] mem_data_out,
   input  logic [31:0] pc_plus4,
   input  logic [15:0] imm,
   output logic [31:0] wr_data
);

   logic [31:0] load_val;

   // low address bits ignored for sub-word loads
   always_comb begin
      case (load_sel)
         LD_LB:   load_val = {{24{mem_data_out[7]}}, mem_data_out[7:0]};
         LD_LBU:  load_val = {24'b0, mem_data_out[7:0]};
         LD_LH:   load_val = {{16{mem_data_out[15]}}, mem_data_out[15:0]};
         LD_LHU:  load_val = {16'b0, mem_data_out[15:0]};
         LD_LUI:  load_val = {imm, 16'b0};
         default: load_val = mem_data_out;  // lw
      endcase
   end

   always_comb begin
      case (wb_sel)
         WB_LOAD: wr_data = load_val;
         WB_LINK: wr_data = pc_plus4;  // jal return address
         default: wr_data = alu_out;
      endcase
   end

endmodule

// File: mips_core.sv
/*
 * Single-cycle MIPS-I subset core. Instruction and data memories are
 * external and answer combinationally in the same cycle. One instruction
 * retires per rising edge until syscall, a reserved encoding or
 * inst_excpt sets halted.
 */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core import mips_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_b,
   output logic [`MIPS_ADDR_W-1:0] inst_addr,
   input  logic [`MIPS_WORD_W-1:0] inst,
   input  logic                    inst_excpt,
   output logic [`MIPS_ADDR_W-1:0] mem_addr,
   output logic [`MIPS_WORD_W-1:0] mem_data_in,
   input  logic [`MIPS_WORD_W-1:0] mem_data_out,
   output logic [3:0]              mem_write_en,
   output logic                    halted
);

   alu_op_t   alu_op;
   pc_sel_t   pc_sel;
   wb_sel_t   wb_sel;
   load_sel_t load_sel;
   logic      alu_src_imm, sign_ext, reg_dst_rd, link;
   logic      reg_we, store, halt_req, branch_ne;
   logic      commit;                         // instruction may update state

   logic [`MIPS_WORD_W-1:0] rs_data, rt_data, imm_ext, alu_b;
   logic [`MIPS_WORD_W-1:0] alu_out, wr_data, pc_plus4;
   logic [4:0]              wr_addr;

   mips_decode decode0 (
      .inst, .alu_op, .alu_src_imm, .sign_ext, .reg_dst_rd, .link,
      .reg_we, .store, .halt_req, .pc_sel, .branch_ne, .wb_sel, .load_sel
   );

   // faulting fetch word is not trusted, treat like halted
   assign commit  = !halted && !inst_excpt;
   assign imm_ext = {{16{sign_ext & inst[15]}}, inst[15:0]};
   assign alu_b   = alu_src_imm ? imm_ext : rt_data;
   assign wr_addr = link ? `MIPS_REG_RA : (reg_dst_rd ? inst[15:11] : inst[20:16]);

   mips_regfile regfile0 (
      .clk, .rst_b,
      .rs_addr (inst[25:21]),
      .rt_addr (inst[20:16]),
      .wr_addr, .wr_data,
      .we      (reg_we & commit),
      .rs_data, .rt_data
   );

   mips_alu alu0 (
      .op (alu_op), .a (rs_data), .b (alu_b), .shamt (inst[10:6]), .y (alu_out)
   );

   mips_fetch fetch0 (
      .clk, .rst_b, .pc_sel, .branch_ne, .rs_data, .rt_data,
      .offset (inst[15:0]),
      .target (inst[25:0]),
      .halt_req, .inst_excpt, .inst_addr, .pc_plus4, .halted
   );

   mips_writeback writeback0 (
      .wb_sel, .load_sel, .alu_out, .mem_data_out, .pc_plus4,
      .imm (inst[15:0]),
      .wr_data
   );

   assign mem_addr     = alu_out[31:2];      // word address
   assign mem_data_in  = rt_data;
   assign mem_write_en = {4{store & commit}}; // sw only, full word

endmodule

// File: mips_tb_asserts.sv
/*
 * Port-level checks on the MIPS core, bound into every mips_core instance.
 * Covers the reset PC, sequential fetch and the frozen halted state.
 */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_tb_asserts (
   input logic        clk,
   input logic        rst_b,
   input logic [29:0] inst_addr,
   input logic [31:0] inst,
   input logic        inst_excpt,
   input logic [3:0]  mem_write_en,
   input logic        halted
);

   localparam logic [29:0] TEXT_WORD = 30'(`MIPS_TEXT_START >> 2);

   logic plain;  // no control transfer, no halt

   assign plain = inst[31:26] inside {`MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI,
                     `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI, `MIPS_OP_LUI,
                     `MIPS_OP_LB, `MIPS_OP_LH, `MIPS_OP_LW, `MIPS_OP_LBU,
                     `MIPS_OP_LHU, `MIPS_OP_SW}
               || (inst[31:26] == `MIPS_OP_RTYPE && inst[5:0] inside {`MIPS_FN_SLL,
                     `MIPS_FN_SRL, `MIPS_FN_SRA, `MIPS_FN_SLLV, `MIPS_FN_SRLV,
                     `MIPS_FN_SRAV, `MIPS_FN_ADD, `MIPS_FN_ADDU, `MIPS_FN_SUB,
                     `MIPS_FN_SUBU, `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_XOR,
                     `MIPS_FN_NOR, `MIPS_FN_SLT});

   reset_pc: assert property (@(posedge clk)
      $rose(rst_b) |-> inst_addr == TEXT_WORD && !halted)
      else $error("fetch did not start at the text segment after reset");

   reset_quiet: assert property (@(posedge clk) !rst_b |-> mem_write_en == 4'h0)
      else $error("memory write during reset");

   fetch_next: assert property (@(posedge clk) disable iff (!rst_b)
      plain && !halted && !inst_excpt |=> inst_addr == $past(inst_addr) + 30'd1)
      else $error("pc did not advance by one word");

   halt_frozen: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> halted && $stable(inst_addr))
      else $error("pc moved or halt cleared while halted");

   halt_no_write: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> mem_write_en == 4'h0)
      else $error("memory write while halted");

endmodule

bind mips_core mips_tb_asserts asserts0 (
   .clk, .rst_b, .inst_addr, .inst, .inst_excpt, .mem_write_en, .halted
);

// File: mips_tb.sv
/*
 * Testbench for the single-cycle MIPS core. Models the instruction ROM and
 * a 64-word data RAM, builds two programs in place and checks every sw
 * against an in-order queue of expected address/data pairs.
 * Program one ends in syscall, program two in a reserved opcode.
 * Program two then reruns with inst_excpt raised on its sw.
 */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_tb;

   localparam logic [29:0] TEXT_WORD = 30'(`MIPS_TEXT_START >> 2);
   localparam logic [31:0] RESERVED  = 32'hfc00_0000;  // opcode 0x3f, undefined

   logic        clk;
   logic        rst_b;
   logic        inst_excpt;
   logic [29:0] inst_addr, mem_addr, rom_idx;
   logic [31:0] inst, mem_data_in, mem_data_out;
   logic [3:0]  mem_write_en;
   logic        halted;

   logic [31:0] rom [128];
   logic [31:0] ram [64];
   logic [31:0] fill [64];          // ram image, reloaded on every reset
   logic [31:0] exp_addr_q [$];
   logic [31:0] exp_data_q [$];
   logic [31:0] w0, w1, ret_addr;
   logic [6:0]  n;                  // next free rom slot
   logic [7:0]  st_off;             // byte offset of next checked store
   int          seed;

   mips_core dut0 (
      .clk, .rst_b, .inst_addr, .inst, .inst_excpt,
      .mem_addr, .mem_data_in, .mem_data_out, .mem_write_en, .halted
   );

   // memories answer in the same cycle
   assign rom_idx      = inst_addr - TEXT_WORD;
   assign inst         = (rom_idx < 30'd128) ? rom[rom_idx[6:0]] : RESERVED;
   assign mem_data_out = ram[mem_addr[5:0]];

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] want_addr;
      logic [31:0] want_data;
      assert (exp_addr_q.size() > 0)
         else abort_run($sformatf("unexpected store of %h to %h at %0t", data, addr, $time));
      want_addr = exp_addr_q.pop_front();
      want_data = exp_data_q.pop_front();
      assert (addr == want_addr && data == want_data)
         else abort_run($sformatf("Mismatch at %0t: store %h to %h, expected %h to %h",
                                  $time, data, addr, want_data, want_addr));
   endtask

   always @(posedge clk) begin
      if (!rst_b) begin
         ram <= fill;
      end else if (mem_write_en == 4'hf) begin
         check_store({mem_addr, 2'b00}, mem_data_in);
         ram[mem_addr[5:0]] <= mem_data_in;
      end
   end

   function automatic logic [31:0] rtype(int rs, int rt, int rd, int sh, logic [5:0] fn);
      return {`MIPS_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
   endfunction

   function automatic logic [31:0] itype(logic [5:0] op, int rs, int rt, logic [15:0] imm);
      return {op, rs[4:0], rt[4:0], imm};
   endfunction

   function automatic logic [31:0] jtype(logic [5:0] op, logic [6:0] idx);
      return {op, 26'(TEXT_WORD + {23'b0, idx})};  // same 256 MB region
   endfunction

   task automatic emit(input logic [31:0] w);
      rom[n] = w;
      n = n + 7'd1;
   endtask

   // sw rt into the next result slot, value is the expected register content
   task automatic expect_sw(input int rt, input logic [31:0] value);
      emit(itype(`MIPS_OP_SW, 0, rt, {8'h00, st_off}));
      exp_addr_q.push_back({24'h0, st_off});
      exp_data_q.push_back(value);
      st_off = st_off + 8'd4;
   endtask

   task automatic poison();
      emit(itype(`MIPS_OP_SW, 0, 1, 16'h00fc));  // never expected
   endtask

   task automatic new_program();
      for (int i = 0; i < 128; i++) begin
         rom[i[6:0]] = RESERVED;  // runaway fetch halts
      end
      n = 7'd0;
      st_off = 8'h40;
   endtask

   task automatic build_first_program();
      new_program();
      emit(itype(`MIPS_OP_LUI, 0, 1, w0[31:16]));
      emit(itype(`MIPS_OP_ORI, 1, 1, w0[15:0]));
      emit(itype(`MIPS_OP_LUI, 0, 2, w1[31:16]));
      emit(itype(`MIPS_OP_ORI, 2, 2, w1[15:0]));
      expect_sw(1, w0);
      expect_sw(2, w1);
      emit(rtype(1, 2, 3, 0, `MIPS_FN_ADD));   // no overflow trap
      expect_sw(3, w0 + w1);
      emit(rtype(1, 2, 3, 0, `MIPS_FN_ADDU));
      expect_sw(3, w0 + w1);
      emit(rtype(1, 2, 3, 0, `MIPS_FN_SUB));
      expect_sw(3, w0 - w1);
      emit(rtype(2, 1, 3, 0, `MIPS_FN_SUBU));
      expect_sw(3, w1 - w0);
      emit(rtype(1, 2, 3, 0, `MIPS_FN_AND));
      expect_sw(3, w0 & w1);
      emit(rtype(1, 2, 3, 0, `MIPS_FN_OR));
      expect_sw(3, w0 | w1);
      emit(rtype(1, 2, 3, 0, `MIPS_FN_XOR));
      expect_sw(3, w0 ^ w1);
      emit(rtype(1, 2, 3, 0, `MIPS_FN_NOR));
      expect_sw(3, ~(w0 | w1));
      emit(rtype(1, 2, 3, 0, `MIPS_FN_SLT));   // signed compare
      expect_sw(3, {31'b0, $signed(w0) < $signed(w1)});
      emit(rtype(0, 2, 3, 7, `MIPS_FN_SLL));
      expect_sw(3, w1 << 7);
      emit(rtype(0, 2, 3, 13, `MIPS_FN_SRL));
      expect_sw(3, w1 >> 13);
      emit(rtype(0, 2, 3, 19, `MIPS_FN_SRA));
      expect_sw(3, 32'($signed(w1) >>> 19));
      emit(rtype(1, 2, 3, 0, `MIPS_FN_SLLV));  // amount from rs[4:0]
      expect_sw(3, w1 << w0[4:0]);
      emit(rtype(1, 2, 3, 0, `MIPS_FN_SRLV));
      expect_sw(3, w1 >> w0[4:0]);
      emit(rtype(1, 2, 3, 0, `MIPS_FN_SRAV));
      expect_sw(3, 32'($signed(w1) >>> w0[4:0]));
      emit(itype(`MIPS_OP_ADDI, 1, 3, 16'h8765));  // sign extended
      expect_sw(3, w0 + 32'hffff_8765);
      emit(itype(`MIPS_OP_ADDIU, 2, 3, 16'h1234));
      expect_sw(3, w1 + 32'h0000_1234);
      emit(itype(`MIPS_OP_ANDI, 1, 3, 16'h8765));  // zero extended
      expect_sw(3, w0 & 32'h0000_8765);
      emit(itype(`MIPS_OP_ORI, 2, 3, 16'hf0f0));
      expect_sw(3, w1 | 32'h0000_f0f0);
      emit(itype(`MIPS_OP_XORI, 1, 3, 16'h8765));
      expect_sw(3, w0 ^ 32'h0000_8765);
      emit(itype(`MIPS_OP_SLTI, 1, 3, 16'h8000));
      expect_sw(3, {31'b0, $signed(w0) < $signed(32'hffff_8000)});
      // loads, sub-word always from the low end of the word
      emit(itype(`MIPS_OP_LW, 0, 4, 16'h0000));
      expect_sw(4, fill[0]);
      emit(itype(`MIPS_OP_LB, 0, 4, 16'h0004));
      expect_sw(4, {{24{fill[1][7]}}, fill[1][7:0]});
      emit(itype(`MIPS_OP_LBU, 0, 4, 16'h0008));
      expect_sw(4, {24'b0, fill[2][7:0]});
      emit(itype(`MIPS_OP_LH, 0, 4, 16'h000c));
      expect_sw(4, {{16{fill[3][15]}}, fill[3][15:0]});
      emit(itype(`MIPS_OP_LHU, 0, 4, 16'h0004));
      expect_sw(4, {16'b0, fill[1][15:0]});
      // branches, both directions
      emit(itype(`MIPS_OP_ADDIU, 0, 5, 16'd5));
      emit(itype(`MIPS_OP_BEQ, 5, 0, 16'd1));  // not taken
      expect_sw(5, 32'd5);
      emit(itype(`MIPS_OP_BNE, 5, 0, 16'd1));  // taken
      poison();
      emit(itype(`MIPS_OP_BEQ, 5, 5, 16'd1));  // taken
      poison();
      emit(itype(`MIPS_OP_BNE, 5, 5, 16'd1));  // not taken
      expect_sw(1, w0);
      emit(jtype(`MIPS_OP_J, n + 7'd2));
      poison();
      ret_addr = `MIPS_TEXT_START + {23'b0, n + 7'd1, 2'b00};  // pc+4 of jal
      emit(jtype(`MIPS_OP_JAL, n + 7'd2));
      poison();
      expect_sw(31, ret_addr);
      emit(itype(`MIPS_OP_LUI, 0, 6, 16'h0040));
      emit(itype(`MIPS_OP_ORI, 6, 6, {7'b0, n + 7'd3, 2'b00}));  // lands past jr
      emit(rtype(6, 0, 0, 0, `MIPS_FN_JR));
      poison();
      emit(rtype(0, 0, 0, 0, `MIPS_FN_SYSCALL));
      poison();
   endtask

   task automatic build_second_program();
      new_program();
      emit(itype(`MIPS_OP_ADDIU, 0, 1, 16'h1234));
      expect_sw(1, 32'h0000_1234);
      emit(RESERVED);
      poison();
   endtask

   task automatic release_reset();
      repeat (10) @(posedge clk);
      #1 rst_b = 1'b1;
   endtask

   task automatic wait_halted(input int limit);
      int cycles;
      cycles = 0;
      while (!halted) begin
         @(posedge clk);
         #1 cycles++;
         if (cycles > limit) abort_run("timeout, core never halted");
      end
   endtask

   initial begin
      seed = 32'h76fd_f4bb;
      rst_b = 1'b0;
      inst_excpt = 1'b0;
      for (int i = 0; i < 64; i++) begin
         fill[i[5:0]] = $random(seed);
      end
      w0 = $random(seed);
      w1 = $random(seed);
      build_first_program();
      release_reset();
      wait_halted(400);
      assert (exp_addr_q.size() == 0)
         else abort_run("expected stores missing at syscall halt");
      rst_b = 1'b0;                // 1 ns past the edge already
      build_second_program();
      release_reset();
      wait_halted(50);
      repeat (4) @(posedge clk);   // halted core stays quiet
      assert (exp_addr_q.size() == 0)
         else abort_run("store missing before reserved opcode halt");
      // rerun with a fetch fault on the sw
      #1 rst_b = 1'b0;
      build_second_program();
      exp_addr_q.delete();         // faulting sw never stores
      exp_data_q.delete();
      release_reset();
      @(posedge clk);              // addiu retired, sw on the inst port
      #1 inst_excpt = 1'b1;
      @(posedge clk);
      #1 inst_excpt = 1'b0;
      assert (halted)
         else abort_run("inst_excpt did not halt the core");
      repeat (4) @(posedge clk);   // plain sw fetched while halted
      $display("Test passed");
      $finish;
   end

endmodule

// File: build.f
+incdir+.
mips_pkg.sv
mips_decode.sv
mips_alu.sv
mips_regfile.sv
mips_fetch.sv
mips_writeback.sv
mips_core.sv
mips_tb_asserts.sv
mips_tb.sv

// File: Makefile
# Verilator build and run of the MIPS core testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module mips_tb -f build.f -o Vmips_tb

# exit status is nonzero when the testbench stops on an error
run: compile
	./obj_dir/Vmips_tb

clean:
	rm -rf obj_dir
